//--- dv/modsq_tb.sv
// Modular squaring testbench
`timescale 1ns/1ps
`default_nettype none

module modsq_tb
   import modsq_pkg::*;
   ;

   localparam operand_t    MODULUS      = DEFAULT_MODULUS;
   localparam logic [31:0] LFSR_SEED    = 32'hc43e;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
   localparam int          NUM_DIRECTED = 3;
   localparam int          NUM_EDGE     = 8;
   localparam int          NUM_RANDOM   = 200;
   localparam int          NUM_B2B      = 20;
   // Busy test counts twice for its trailing quiet period
   localparam int          NUM_TESTS    = NUM_DIRECTED + NUM_EDGE + NUM_RANDOM + NUM_B2B + 2;
   localparam int unsigned MAX_CYCLES   = 12 * NUM_TESTS + 100;
   localparam int          VALID_DELAY  = 9;
   localparam int          VALID_LIMIT  = 12;

   // One outstanding squaring as seen by the checker
   typedef struct packed {
      operand_t    op;
      result_t     exp;
      logic [31:0] due;
   } expect_t;

   logic     clk;
   logic     reset;
   logic     start;
   operand_t operand_in;
   logic     valid;
   result_t  result;

   int unsigned cycle_count = 0;
   logic [31:0] lfsr_state;
   expect_t     pending[$];

   modsq_top #(
      .MODULUS (MODULUS)
   ) i_dut (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .operand_in (operand_in),
      .valid      (valid),
      .result     (result)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input square_t expected, input square_t actual);
      if (expected !== actual) begin
         abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, expected, actual));
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per operand bit
   function automatic operand_t random_operand();
      operand_t value;
      value = '0;
      for (int i = 0; i < OPERAND_LEN; i++) begin
         value = {value[OPERAND_LEN-2:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return value;
   endfunction

   // Low square half plus each upper byte reduced with its own weight
   function automatic result_t reference_result(input operand_t op);
      square_t sq;
      square_t weight;
      square_t term;
      square_t total;
      sq    = square_t'(op) * square_t'(op);
      total = square_t'(sq[OPERAND_LEN-1:0]);
      for (int j = 0; j < NUM_WORDS; j++) begin
         weight = (square_t'(1) << (OPERAND_LEN + WORD_LEN * j)) % square_t'(MODULUS);
         term   = (square_t'(sq[OPERAND_LEN + WORD_LEN * j +: WORD_LEN]) * weight)
                  % square_t'(MODULUS);
         total  = total + term;
      end
      return total[RESULT_LEN-1:0];
   endfunction

   function automatic expect_t make_expect(input operand_t op);
      expect_t e;
      e.op  = op;
      e.exp = reference_result(op);
      e.due = cycle_count + VALID_DELAY;
      return e;
   endfunction

   // Called on a falling edge, returns on the falling edge that sees valid
   task automatic square_op(input operand_t op);
      int waited;
      pending.push_back(make_expect(op));
      start      = 1'b1;
      operand_in = op;
      @(negedge clk);
      start      = 1'b0;
      operand_in = '0;
      waited     = 0;
      while (valid !== 1'b1) begin
         if (waited > VALID_LIMIT) begin
            abort_run("No valid arrived after an accepted start");
         end
         @(negedge clk);
         waited++;
      end
   endtask

   // Starts while busy must be dropped
   task automatic busy_starts(input operand_t op);
      pending.push_back(make_expect(op));
      start      = 1'b1;
      operand_in = op;
      @(negedge clk);
      // One extra start in each busy state, MUL0 through SUM
      for (int i = 0; i < 8; i++) begin
         start      = 1'b1;
         operand_in = random_operand();
         @(negedge clk);
      end
      start      = 1'b0;
      operand_in = '0;
      while (valid !== 1'b1) begin
         @(negedge clk);
      end
      repeat (VALID_LIMIT) @(negedge clk);
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         abort_run($sformatf("Timeout after %0d cycles", cycle_count));
      end
   end

   // Outputs settle after the rising edge, so compare on the falling one
   always @(negedge clk) begin : compare_results
      expect_t e;
      if (valid === 1'b1) begin
         if (pending.size() == 0) begin
            abort_run("Valid asserted with no squaring in flight");
         end else if (cycle_count != pending[0].due) begin
            abort_run($sformatf("Valid at cycle %0d but expected at cycle %0d",
                                cycle_count, pending[0].due));
         end else begin
            e = pending.pop_front();
            check_value("result", square_t'(e.exp), square_t'(result));
            check_value("result mod MODULUS",
                        (square_t'(e.op) * square_t'(e.op)) % square_t'(MODULUS),
                        square_t'(result) % square_t'(MODULUS));
         end
      end else if (valid !== 1'b0 && cycle_count > 0) begin
         abort_run("Valid is unknown after the first clock edge");
      end
   end

   initial begin : run_tests
      clk        = 1'b0;
      reset      = 1'b1;
      start      = 1'b0;
      operand_in = '0;
      lfsr_state = LFSR_SEED;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);

      // Trivial and all-ones operands
      square_op('0);
      square_op(operand_t'(1));
      square_op('1);

      // Modulus boundary, single segments and cross-term pairs
      square_op(MODULUS - 1);
      square_op(MODULUS);
      for (int s = 0; s < NUM_SEGMENTS; s++) begin
         square_op(operand_t'(64'hFFFF) << (SEG_LEN * s));
      end
      square_op(64'hFFFF_0000_0000_FFFF);
      square_op(64'h0000_FFFF_FFFF_0000);

      for (int i = 0; i < NUM_RANDOM; i++) begin
         square_op(random_operand());
      end

      // Each start lands in the cycle right after the previous valid
      for (int i = 0; i < NUM_B2B; i++) begin
         square_op(random_operand());
      end

      busy_starts(random_operand());

      start = 1'b0;
      repeat (50) @(negedge clk);

      if (pending.size() != 0) begin
         abort_run($sformatf("%0d squarings never produced a valid", pending.size()));
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- hdl/modsq_pkg.sv
// Modular squaring shared definitions
`default_nettype none

package modsq_pkg;

   // Operand geometry
   localparam int WORD_LEN     = 8;
   localparam int NUM_WORDS    = 8;
   localparam int NUM_SEGMENTS = 4;
   localparam int SEG_WORDS    = 2;
   localparam int SEG_LEN      = SEG_WORDS * WORD_LEN;

   localparam int OPERAND_LEN  = NUM_WORDS * WORD_LEN;
   localparam int SQUARE_LEN   = 2 * OPERAND_LEN;
   // Lower half plus eight table values, each below 2^64
   localparam int RESULT_LEN   = OPERAND_LEN + 4;

   // Largest prime below 2^64
   localparam logic [OPERAND_LEN-1:0] DEFAULT_MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

   typedef logic [OPERAND_LEN-1:0]           operand_t;
   typedef logic [SQUARE_LEN-1:0]            square_t;
   typedef logic [RESULT_LEN-1:0]            result_t;
   typedef logic [$clog2(NUM_SEGMENTS)-1:0]  seg_sel_t;

   // Segment pair request for one multiplier
   typedef struct packed {
      logic     issue;
      seg_sel_t a_sel;
      seg_sel_t b_sel;
      logic     dbl;
   } mul_cmd_t;

   // Registered multiplier output, value already doubled for cross terms
   typedef struct packed {
      logic                 valid;
      logic [2*SEG_LEN:0]   value;
      logic [2:0]           position;
   } seg_product_t;

   typedef enum logic [3:0] {
      IDLE,
      MUL0,
      MUL1,
      MUL2,
      MUL3,
      MUL4,
      DRAIN,
      LOOKUP,
      SUM
   } sq_state_t;

endpackage

`default_nettype wire

//--- hdl/modsq_top.sv
// Modular squaring unit top level
`timescale 1ns/1ps
`default_nettype none

module modsq_top
   import modsq_pkg::*;
   #(
      parameter operand_t MODULUS = DEFAULT_MODULUS
   )
   (
      input  logic     clk,
      input  logic     reset,
      input  logic     start,
      input  operand_t operand_in,
      output logic     valid,
      output result_t  result
   );

   operand_t                    operand;
   mul_cmd_t                    cmd0;
   mul_cmd_t                    cmd1;
   seg_product_t                product0;
   seg_product_t                product1;
   logic                        clear_acc;
   logic                        lookup;
   logic                        sum_en;
   square_t                     square;
   operand_t [NUM_WORDS-1:0]    table_vals;

   square_sequencer i_sequencer (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .operand_in (operand_in),
      .operand    (operand),
      .cmd0       (cmd0),
      .cmd1       (cmd1),
      .clear_acc  (clear_acc),
      .lookup     (lookup),
      .sum_en     (sum_en)
   );

   segment_multiplier i_mul0 (
      .clk     (clk),
      .reset   (reset),
      .operand (operand),
      .cmd     (cmd0),
      .product (product0)
   );

   segment_multiplier i_mul1 (
      .clk     (clk),
      .reset   (reset),
      .operand (operand),
      .cmd     (cmd1),
      .product (product1)
   );

   product_accumulator i_accumulator (
      .clk       (clk),
      .reset     (reset),
      .clear_acc (clear_acc),
      .product0  (product0),
      .product1  (product1),
      .square    (square)
   );

   // Upper square half addresses the tables
   reduction_rom #(
      .MODULUS (MODULUS)
   ) i_rom (
      .clk        (clk),
      .lookup     (lookup),
      .square_hi  (square[SQUARE_LEN-1:OPERAND_LEN]),
      .table_vals (table_vals)
   );

   reduction_adder i_adder (
      .clk        (clk),
      .reset      (reset),
      .sum_en     (sum_en),
      .square_lo  (square[OPERAND_LEN-1:0]),
      .table_vals (table_vals),
      .result     (result),
      .valid      (valid)
   );

endmodule

`default_nettype wire

//--- hdl/product_accumulator.sv
// Square product accumulator
`timescale 1ns/1ps
`default_nettype none

module product_accumulator
   import modsq_pkg::*;
   (
      input  logic         clk,
      input  logic         reset,
      input  logic         clear_acc,
      input  seg_product_t product0,
      input  seg_product_t product1,
      output square_t      square
   );

   square_t add0;
   square_t add1;

   // Place a product at its segment offset, zero when not valid
   function automatic square_t align(input seg_product_t p);
      square_t aligned;
      aligned = '0;
      if (p.valid) begin
         aligned = square_t'(p.value) << (p.position * SEG_LEN);
      end
      return aligned;
   endfunction

   assign add0 = align(product0);
   assign add1 = align(product1);

   always_ff @(posedge clk) begin
      if (reset || clear_acc) begin
         square <= '0;
      end else begin
         square <= square + add0 + add1;
      end
   end

   // A new squaring is only accepted once the previous products have drained
   assert property (@(posedge clk) disable iff (reset)
      clear_acc |-> !(product0.valid || product1.valid));

endmodule

`default_nettype wire

//--- hdl/reduction_adder.sv
// Reduction sum and result register
`timescale 1ns/1ps
`default_nettype none

module reduction_adder
   import modsq_pkg::*;
   (
      input  logic                     clk,
      input  logic                     reset,
      input  logic                     sum_en,
      input  operand_t                 square_lo,
      input  operand_t [NUM_WORDS-1:0] table_vals,
      output result_t                  result,
      output logic                     valid
   );

   result_t sum;

   // Lower square half plus one reduced value per upper byte
   always_comb begin
      sum = result_t'(square_lo);
      for (int j = 0; j < NUM_WORDS; j++) begin
         sum = sum + result_t'(table_vals[j]);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else begin
         valid <= sum_en;
      end
   end

   // Held until the next squaring completes
   always_ff @(posedge clk) begin
      if (sum_en) begin
         result <= sum;
      end
   end

endmodule

`default_nettype wire

//--- hdl/reduction_rom.sv
// Reduction lookup tables
`timescale 1ns/1ps
`default_nettype none

module reduction_rom
   import modsq_pkg::*;
   #(
      parameter operand_t MODULUS = DEFAULT_MODULUS
   )
   (
      input  logic                     clk,
      input  logic                     lookup,
      input  operand_t                 square_hi,
      output operand_t [NUM_WORDS-1:0] table_vals
   );

   localparam int LUT_DEPTH = 2 ** WORD_LEN;

   typedef operand_t [LUT_DEPTH-1:0] lut_t;

   // Entry k of table j is k * 2^(8*(8+j)) mod MODULUS
   function automatic lut_t build_table(input int j);
      lut_t                 tbl;
      logic [OPERAND_LEN:0] weight;
      logic [OPERAND_LEN:0] acc;
      weight = 1;
      for (int i = 0; i < OPERAND_LEN + WORD_LEN * j; i++) begin
         weight = weight << 1;
         if (weight >= {1'b0, MODULUS}) begin
            weight = weight - {1'b0, MODULUS};
         end
      end
      acc = '0;
      for (int k = 0; k < LUT_DEPTH; k++) begin
         tbl[k] = acc[OPERAND_LEN-1:0];
         acc = acc + weight;
         if (acc >= {1'b0, MODULUS}) begin
            acc = acc - {1'b0, MODULUS};
         end
      end
      return tbl;
   endfunction

   for (genvar j = 0; j < NUM_WORDS; j++) begin : g_table
      localparam lut_t LUT = build_table(j);

      operand_t rd_data;

      always_ff @(posedge clk) begin
         if (lookup) begin
            rd_data <= LUT[square_hi[j*WORD_LEN +: WORD_LEN]];
         end
      end

      assign table_vals[j] = rd_data;
   end

endmodule

`default_nettype wire

//--- hdl/segment_multiplier.sv
// Segment pair multiplier
`timescale 1ns/1ps
`default_nettype none

module segment_multiplier
   import modsq_pkg::*;
   (
      input  logic         clk,
      input  logic         reset,
      input  operand_t     operand,
      input  mul_cmd_t     cmd,
      output seg_product_t product
   );

   logic [SEG_LEN-1:0]   seg_a;
   logic [SEG_LEN-1:0]   seg_b;
   logic [2*SEG_LEN-1:0] prod;
   logic [2*SEG_LEN:0]   prod_scaled;

   assign seg_a = operand[cmd.a_sel*SEG_LEN +: SEG_LEN];
   assign seg_b = operand[cmd.b_sel*SEG_LEN +: SEG_LEN];
   assign prod  = seg_a * seg_b;

   // Cross terms appear twice in the square
   assign prod_scaled = cmd.dbl ? {prod, 1'b0} : {1'b0, prod};

   always_ff @(posedge clk) begin
      if (reset) begin
         product.valid <= 1'b0;
      end else begin
         product.valid <= cmd.issue;
      end
   end

   always_ff @(posedge clk) begin
      product.value    <= prod_scaled;
      product.position <= 3'(cmd.a_sel) + 3'(cmd.b_sel);
   end

   // Only squared segments go in unscaled
   assert property (@(posedge clk) disable iff (reset)
      (cmd.issue && !cmd.dbl) |-> (cmd.a_sel == cmd.b_sel));

endmodule

`default_nettype wire

//--- hdl/square_sequencer.sv
// Squaring schedule sequencer
`timescale 1ns/1ps
`default_nettype none

module square_sequencer
   import modsq_pkg::*;
   (
      input  logic     clk,
      input  logic     reset,
      input  logic     start,
      input  operand_t operand_in,
      output operand_t operand,
      output mul_cmd_t cmd0,
      output mul_cmd_t cmd1,
      output logic     clear_acc,
      output logic     lookup,
      output logic     sum_en
   );

   sq_state_t state;
   sq_state_t next_state;
   logic      accept;

   // Cross terms are the pairs with different segments
   function automatic mul_cmd_t make_cmd(input seg_sel_t a, input seg_sel_t b);
      mul_cmd_t cmd;
      cmd.issue = 1'b1;
      cmd.a_sel = a;
      cmd.b_sel = b;
      cmd.dbl   = (a != b);
      return cmd;
   endfunction

   // Starts outside IDLE are dropped
   assign accept    = (state == IDLE) && start;
   assign clear_acc = accept;
   assign lookup    = (state == LOOKUP);
   assign sum_en    = (state == SUM);

   always_comb begin
      next_state = state;
      case (state)
         IDLE:    next_state = accept ? MUL0 : IDLE;
         MUL0:    next_state = MUL1;
         MUL1:    next_state = MUL2;
         MUL2:    next_state = MUL3;
         MUL3:    next_state = MUL4;
         MUL4:    next_state = DRAIN;
         DRAIN:   next_state = LOOKUP;
         LOOKUP:  next_state = SUM;
         SUM:     next_state = IDLE;
         default: next_state = IDLE;
      endcase
   end

   // Segment pairs per cycle, A is segment 0
   always_comb begin
      cmd0 = '0;
      cmd1 = '0;
      case (state)
         MUL0: begin
            cmd0 = make_cmd(2'd0, 2'd0);
            cmd1 = make_cmd(2'd1, 2'd1);
         end
         MUL1: begin
            cmd0 = make_cmd(2'd2, 2'd2);
            cmd1 = make_cmd(2'd3, 2'd3);
         end
         MUL2: begin
            cmd0 = make_cmd(2'd0, 2'd1);
            cmd1 = make_cmd(2'd0, 2'd2);
         end
         MUL3: begin
            cmd0 = make_cmd(2'd0, 2'd3);
            cmd1 = make_cmd(2'd1, 2'd2);
         end
         MUL4: begin
            cmd0 = make_cmd(2'd1, 2'd3);
            cmd1 = make_cmd(2'd2, 2'd3);
         end
         default: begin
            cmd0 = '0;
            cmd1 = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Operand stays put until the next accepted start
   always_ff @(posedge clk) begin
      if (accept) begin
         operand <= operand_in;
      end
   end

   // Clear, lookup and sum phases never overlap
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({clear_acc, lookup, sum_en}));

endmodule

`default_nettype wire

//--- modsq.f
hdl/modsq_pkg.sv
hdl/square_sequencer.sv
hdl/segment_multiplier.sv
hdl/product_accumulator.sv
hdl/reduction_rom.sv
hdl/reduction_adder.sv
hdl/modsq_top.sv
dv/modsq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the modular squaring testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module modsq_tb \
   -f modsq.f \
   --Mdir obj_dir -o modsq_sim

# The log decides the outcome, so keep running if the simulator exits nonzero
./obj_dir/modsq_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx '=== PASS ===' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
